// ==== logic/ifu_ctrl_pkg.sv ====
// Control-side definitions of the fetch stage: address width and the selectors
// that the controller drives to steer the next PC.

package ifu_ctrl_pkg;

  // instruction address and data width
  localparam int unsigned AddrWidth = 32;

  // source of the next fetch address on a PC set
  typedef enum logic [2:0] {
    PC_BOOT = 3'd0,
    PC_JUMP = 3'd1,
    PC_EXC  = 3'd2,
    PC_ERET = 3'd3,
    PC_DRET = 3'd4
  } pc_sel_e;

  // source of the exception vector when PC_EXC is selected
  typedef enum logic [1:0] {
    EXC_PC_EXC     = 2'd0,
    EXC_PC_IRQ     = 2'd1,
    EXC_PC_DBD     = 2'd2,
    EXC_PC_DBG_EXC = 2'd3
  } exc_pc_sel_e;

endpackage

// ==== logic/ifu_bus_pkg.sv ====
// Data-side types of the fetch stage: the instruction bus request and response,
// and the fetched instruction as it moves from the buffer to the ID stage.

package ifu_bus_pkg;

  // request toward instruction memory
  typedef struct packed {
    logic                                req;
    logic [ifu_ctrl_pkg::AddrWidth-1:0] addr;
  } instr_req_t;

  // response from instruction memory
  typedef struct packed {
    logic                                gnt;
    logic                                rvalid;
    logic [ifu_ctrl_pkg::AddrWidth-1:0] rdata;
    logic                                err;
  } instr_rsp_t;

  // one fetched word with the address it was read from
  typedef struct packed {
    logic [ifu_ctrl_pkg::AddrWidth-1:0] rdata;
    logic [ifu_ctrl_pkg::AddrWidth-1:0] addr;
    logic                                err;  // bus error on this fetch
  } fetch_item_t;

endpackage

// ==== logic/ifu_pc_select.sv ====
// Next-PC selection for the fetch stage. Purely combinational; the result is
// consumed by the prefetch buffer in the cycle of a PC set.

`timescale 1ns/100ps

module ifu_pc_select #(
  parameter logic [ifu_ctrl_pkg::AddrWidth-1:0] DmHaltAddr      = 32'h1A110800,
  parameter logic [ifu_ctrl_pkg::AddrWidth-1:0] DmExceptionAddr = 32'h1A110808
) (
  input  ifu_ctrl_pkg::pc_sel_e               pc_mux_i,
  input  ifu_ctrl_pkg::exc_pc_sel_e           exc_pc_mux_i,
  input  logic                                pc_set_i,
  input  logic [ifu_ctrl_pkg::AddrWidth-1:0] boot_addr_i,
  input  logic [ifu_ctrl_pkg::AddrWidth-1:0] branch_target_i,
  input  logic [ifu_ctrl_pkg::AddrWidth-1:0] csr_mepc_i,
  input  logic [ifu_ctrl_pkg::AddrWidth-1:0] csr_depc_i,
  input  logic [ifu_ctrl_pkg::AddrWidth-1:0] csr_mtvec_i,
  output logic [ifu_ctrl_pkg::AddrWidth-1:0] fetch_addr_o,
  output logic                                csr_mtvec_init_o
);

  import ifu_ctrl_pkg::*;

  logic [AddrWidth-1:0] exc_pc;
  logic [AddrWidth-1:0] next_pc;

  // exception vector, traps use the mtvec base
  always_comb begin
    unique case (exc_pc_mux_i)
      EXC_PC_EXC:     exc_pc = {csr_mtvec_i[AddrWidth-1:2], 2'b00};
      EXC_PC_IRQ:     exc_pc = {csr_mtvec_i[AddrWidth-1:2], 2'b00};
      EXC_PC_DBD:     exc_pc = DmHaltAddr;
      EXC_PC_DBG_EXC: exc_pc = DmExceptionAddr;
      default:        exc_pc = {csr_mtvec_i[AddrWidth-1:2], 2'b00};
    endcase
  end

  always_comb begin
    unique case (pc_mux_i)
      PC_BOOT: next_pc = {boot_addr_i[AddrWidth-1:2], 2'b00};
      PC_JUMP: next_pc = branch_target_i;
      PC_EXC:  next_pc = exc_pc;
      PC_ERET: next_pc = csr_mepc_i;   // return from trap
      PC_DRET: next_pc = csr_depc_i;   // return from debug mode
      default: next_pc = {boot_addr_i[AddrWidth-1:2], 2'b00};
    endcase
  end

  // only 32-bit instructions, so every fetch is word aligned
  assign fetch_addr_o = {next_pc[AddrWidth-1:2], 2'b00};

  // mtvec is initialised from the boot address when booting
  assign csr_mtvec_init_o = pc_set_i & (pc_mux_i == PC_BOOT);

endmodule

// ==== logic/ifu_prefetch_buffer.sv ====
// Prefetch buffer: issues word fetches on the instruction bus with several
// requests in flight and queues the returned words for the ID stage.
// A branch flushes the queue and drops responses that are still on the way.

`timescale 1ns/100ps

module ifu_prefetch_buffer #(
  parameter int unsigned FifoDepth = 2
) (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                req_i,
  input  logic                                branch_i,
  input  logic [ifu_ctrl_pkg::AddrWidth-1:0] addr_i,
  input  logic                                ready_i,
  input  ifu_bus_pkg::instr_rsp_t             instr_rsp_i,
  output logic                                valid_o,
  output ifu_bus_pkg::fetch_item_t            item_o,
  output ifu_bus_pkg::instr_req_t             instr_req_o
);

  import ifu_ctrl_pkg::*;
  import ifu_bus_pkg::*;

  localparam int unsigned CntW = $clog2(FifoDepth + 1);
  localparam int unsigned PtrW = (FifoDepth > 1) ? $clog2(FifoDepth) : 1;

  logic                 started_q;
  logic                 hold_q, hold_stale_q;
  logic [AddrWidth-1:0] hold_addr_q;
  logic [AddrWidth-1:0] fetch_addr_q;
  logic [AddrWidth-1:0] resp_addr_q;
  logic [CntW-1:0]      pend_q, pend_d;
  logic [CntW-1:0]      discard_q, discard_d;
  logic [CntW:0]        used;
  logic                 room, new_req, bus_req, gnt_acc;
  logic [AddrWidth-1:0] bus_addr;
  logic                 push, drop, pop;

  fetch_item_t          fifo_q [FifoDepth];
  logic [PtrW-1:0]      wr_ptr_q, rd_ptr_q;
  logic [CntW-1:0]      fifo_cnt_q;

  // stored plus outstanding words must fit into the queue
  assign used = fifo_cnt_q + pend_q;
  assign room = used < (CntW + 1)'(FifoDepth);

  // a request that was not granted stays on the bus with the same address,
  // even across a branch
  assign new_req  = req_i & started_q & ~hold_q & ~branch_i & room;
  assign bus_req  = hold_q | new_req;
  assign bus_addr = hold_q ? hold_addr_q : fetch_addr_q;
  assign gnt_acc  = bus_req & instr_rsp_i.gnt;

  assign instr_req_o = '{req: bus_req, addr: bus_addr};

  // responses of a flushed stream never enter the queue
  assign drop = instr_rsp_i.rvalid & ((discard_q != '0) | branch_i);
  assign push = instr_rsp_i.rvalid & ~drop;
  assign pop  = valid_o & ready_i;

  assign pend_d = pend_q + CntW'(gnt_acc) - CntW'(instr_rsp_i.rvalid);

  always_comb begin
    discard_d = discard_q;
    if (branch_i) begin
      // everything still outstanding belongs to the old stream
      discard_d = pend_d;
    end else begin
      if (drop) begin
        discard_d = discard_d - CntW'(1);
      end
      if (gnt_acc && hold_stale_q) begin
        discard_d = discard_d + CntW'(1);
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      started_q    <= 1'b0;
      hold_q       <= 1'b0;
      hold_stale_q <= 1'b0;
      fetch_addr_q <= '0;
      resp_addr_q  <= '0;
      pend_q       <= '0;
      discard_q    <= '0;
    end else begin
      pend_q       <= pend_d;
      discard_q    <= discard_d;
      hold_q       <= bus_req & ~instr_rsp_i.gnt;
      hold_stale_q <= bus_req & ~instr_rsp_i.gnt & (branch_i | hold_stale_q);
      if (branch_i) begin
        started_q    <= 1'b1;
        fetch_addr_q <= addr_i;
        resp_addr_q  <= addr_i;
      end else begin
        if (gnt_acc && !hold_stale_q) begin
          fetch_addr_q <= fetch_addr_q + AddrWidth'(4);
        end
        // address of the next word that will be kept
        if (push) begin
          resp_addr_q <= resp_addr_q + AddrWidth'(4);
        end
      end
    end
  end

  // address of a request waiting for its grant
  always_ff @(posedge clk_i) begin
    if (!hold_q) begin
      hold_addr_q <= fetch_addr_q;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      fifo_cnt_q <= '0;
    end else if (branch_i) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      fifo_cnt_q <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(FifoDepth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(FifoDepth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      fifo_cnt_q <= fifo_cnt_q + CntW'(push) - CntW'(pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      fifo_q[wr_ptr_q] <= '{rdata: instr_rsp_i.rdata, addr: resp_addr_q, err: instr_rsp_i.err};
    end
  end

  assign valid_o = (fifo_cnt_q != '0);

  always_comb begin
    item_o = fifo_q[rd_ptr_q];
    // when empty, show the address of the word that comes next
    if (!valid_o) begin
      item_o.addr = resp_addr_q;
    end
  end

endmodule

// ==== logic/ifu_id_reg.sv ====
// IF-ID pipeline register. Takes an instruction from the prefetch buffer when
// the ID stage is ready and flags it as valid and new.

`timescale 1ns/100ps

module ifu_id_reg (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  ifu_bus_pkg::fetch_item_t item_i,
  input  logic                     valid_i,
  input  logic                     id_in_ready_i,
  input  logic                     pc_set_i,
  input  logic                     instr_valid_clear_i,
  output logic                     ready_o,
  output ifu_bus_pkg::fetch_item_t item_o,
  output logic                     valid_o,
  output logic                     new_o,
  output logic                     accept_o
);

  logic accept;
  logic valid_d, valid_q;
  logic new_q;

  // the buffer pops in the same cycle
  assign accept   = valid_i & id_in_ready_i;
  assign ready_o  = accept;
  assign accept_o = accept;

  // a PC set in the accept cycle squashes the incoming instruction,
  // otherwise valid holds until the ID stage clears it
  assign valid_d = (accept & ~pc_set_i) | (valid_q & ~instr_valid_clear_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      new_q   <= 1'b0;
    end else begin
      valid_q <= valid_d;
      new_q   <= accept;
    end
  end

  // frozen while ID stalls
  always_ff @(posedge clk_i) begin
    if (accept) begin
      item_o <= item_i;
    end
  end

  assign valid_o = valid_q;
  assign new_o   = new_q;

endmodule

// ==== logic/ifu_pc_check.sv ====
// PC increment checker. Flags an alert when the address in IF does not follow
// the instruction in ID by one word although no redirect happened in between.

`timescale 1ns/100ps

module ifu_pc_check (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                accept_i,
  input  logic                                branch_i,
  input  logic [ifu_ctrl_pkg::AddrWidth-1:0] pc_if_i,
  input  ifu_bus_pkg::fetch_item_t            id_item_i,
  output logic                                alert_o
);

  import ifu_ctrl_pkg::*;

  logic                 seq_d, seq_q;
  logic [AddrWidth-1:0] id_addr_incr;

  // any redirect breaks the sequence, also a fresh start after reset
  assign seq_d = (seq_q | accept_i) & ~branch_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      seq_q <= 1'b0;
    end else begin
      seq_q <= seq_d;
    end
  end

  assign id_addr_incr = id_item_i.addr + AddrWidth'(4);

  assign alert_o = seq_q & (pc_if_i != id_addr_incr);

endmodule

// ==== logic/ifu_top.sv ====
// Instruction fetch stage for 32-bit RISC-V instructions. Selects the next PC,
// prefetches over the instruction bus and hands instructions to the ID stage.

`timescale 1ns/100ps

module ifu_top #(
  parameter logic [ifu_ctrl_pkg::AddrWidth-1:0] DmHaltAddr      = 32'h1A110800,
  parameter logic [ifu_ctrl_pkg::AddrWidth-1:0] DmExceptionAddr = 32'h1A110808,
  parameter int unsigned                         FifoDepth       = 2
) (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic [ifu_ctrl_pkg::AddrWidth-1:0] boot_addr_i,
  input  logic                                req_i,
  input  logic                                pc_set_i,
  input  ifu_ctrl_pkg::pc_sel_e               pc_mux_i,
  input  ifu_ctrl_pkg::exc_pc_sel_e           exc_pc_mux_i,
  input  logic [ifu_ctrl_pkg::AddrWidth-1:0] branch_target_i,
  input  logic [ifu_ctrl_pkg::AddrWidth-1:0] csr_mepc_i,
  input  logic [ifu_ctrl_pkg::AddrWidth-1:0] csr_depc_i,
  input  logic [ifu_ctrl_pkg::AddrWidth-1:0] csr_mtvec_i,
  input  logic                                id_in_ready_i,
  input  logic                                instr_valid_clear_i,
  input  ifu_bus_pkg::instr_rsp_t             instr_rsp_i,
  output ifu_bus_pkg::instr_req_t             instr_req_o,
  output ifu_bus_pkg::fetch_item_t            instr_id_o,
  output logic                                instr_valid_id_o,
  output logic                                instr_new_id_o,
  output logic [ifu_ctrl_pkg::AddrWidth-1:0] pc_if_o,
  output logic                                csr_mtvec_init_o,
  output logic                                pc_mismatch_alert_o
);

  import ifu_ctrl_pkg::*;
  import ifu_bus_pkg::*;

  logic [AddrWidth-1:0] fetch_addr;
  logic                 fetch_valid;
  logic                 fetch_ready;
  fetch_item_t          fetch_item;
  logic                 id_accept;

  ifu_pc_select #(
    .DmHaltAddr      (DmHaltAddr),
    .DmExceptionAddr (DmExceptionAddr)
  ) u_pc_select (
    .pc_mux_i         (pc_mux_i),
    .exc_pc_mux_i     (exc_pc_mux_i),
    .pc_set_i         (pc_set_i),
    .boot_addr_i      (boot_addr_i),
    .branch_target_i  (branch_target_i),
    .csr_mepc_i       (csr_mepc_i),
    .csr_depc_i       (csr_depc_i),
    .csr_mtvec_i      (csr_mtvec_i),
    .fetch_addr_o     (fetch_addr),
    .csr_mtvec_init_o (csr_mtvec_init_o)
  );

  ifu_prefetch_buffer #(
    .FifoDepth (FifoDepth)
  ) u_prefetch_buffer (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_i       (req_i),
    .branch_i    (pc_set_i),
    .addr_i      (fetch_addr),
    .ready_i     (fetch_ready),
    .instr_rsp_i (instr_rsp_i),
    .valid_o     (fetch_valid),
    .item_o      (fetch_item),
    .instr_req_o (instr_req_o)
  );

  ifu_id_reg u_id_reg (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .item_i              (fetch_item),
    .valid_i             (fetch_valid),
    .id_in_ready_i       (id_in_ready_i),
    .pc_set_i            (pc_set_i),
    .instr_valid_clear_i (instr_valid_clear_i),
    .ready_o             (fetch_ready),
    .item_o              (instr_id_o),
    .valid_o             (instr_valid_id_o),
    .new_o               (instr_new_id_o),
    .accept_o            (id_accept)
  );

  ifu_pc_check u_pc_check (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .accept_i  (id_accept),
    .branch_i  (pc_set_i),
    .pc_if_i   (fetch_item.addr),
    .id_item_i (instr_id_o),
    .alert_o   (pc_mismatch_alert_o)
  );

  assign pc_if_o = fetch_item.addr;

endmodule

// ==== dv/ifu_tb.sv ====
// Testbench for the fetch stage. Applies a table of redirects, serves the
// instruction bus from a memory model that returns the inverted address,
// and checks every instruction that reaches the ID stage.

`timescale 1ns/100ps

module ifu_tb;

  import ifu_ctrl_pkg::*;
  import ifu_bus_pkg::*;

  // each row is one redirect
  // bit k of ready_pat drives id_in_ready_i k cycles after the set, and a
  // pattern of zero means random stall stretches
  typedef struct packed {
    pc_sel_e              pc_mux;
    exc_pc_sel_e          exc_mux;
    logic [AddrWidth-1:0] target;
    logic [AddrWidth-1:0] first_pc;
    logic [7:0]           count;
    logic [7:0]           ready_pat;
  } row_t;

  localparam int NumRows = 10;
  localparam logic [AddrWidth-1:0] ErrLo = 32'h0000_2000;
  localparam logic [AddrWidth-1:0] ErrHi = 32'h0000_2010;

  logic                 clk_i = 1'b0;
  logic                 rst_ni;
  logic [AddrWidth-1:0] boot_addr_i, branch_target_i;
  logic [AddrWidth-1:0] csr_mepc_i, csr_depc_i, csr_mtvec_i;
  logic                 req_i, pc_set_i, id_in_ready_i, instr_valid_clear_i;
  pc_sel_e              pc_mux_i;
  exc_pc_sel_e          exc_pc_mux_i;
  instr_rsp_t           instr_rsp_i;
  instr_req_t           instr_req_o;
  fetch_item_t          instr_id_o;
  logic                 instr_valid_id_o, instr_new_id_o;
  logic [AddrWidth-1:0] pc_if_o;
  logic                 csr_mtvec_init_o, pc_mismatch_alert_o;

  row_t                 rows [NumRows];
  row_t                 cur_row;
  integer               seed;
  int                   cycle = 0;
  int                   limit;
  int                   errors = 0;
  int                   n_instr = 0;
  int                   consumed = 0;
  int                   grant_lat = 1;
  int                   last_due = 0;
  int                   row_cyc = 0;
  int                   stall_left = 0;
  logic [AddrWidth-1:0] pend_addr [$];
  int                   pend_due [$];
  logic                 bus_waiting = 1'b0;
  logic [AddrWidth-1:0] waiting_addr;
  logic                 started = 1'b0;
  logic                 valid_exp_q = 1'b0;
  logic                 clear_prev = 1'b0;
  logic                 ready_prev = 1'b0;
  logic                 boot_set = 1'b0;
  logic [AddrWidth-1:0] exp_pc;

  ifu_top uut (.*);

  always #4 clk_i = ~clk_i;

  function automatic logic in_err_window(input logic [AddrWidth-1:0] a);
    return (a >= ErrLo) && (a < ErrHi);
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      errors++;
      $display("** Error: %s = %h, expected %h", name, got, exp);
    end
  endtask

  // sources not selected by the row carry values that must never show up
  task automatic load_sources();
    boot_addr_i     = 32'h0BAD_0000;
    branch_target_i = 32'h0BAD_1000;
    csr_mepc_i      = 32'h0BAD_2000;
    csr_depc_i      = 32'h0BAD_3000;
    csr_mtvec_i     = 32'h0BAD_4000;
    case (cur_row.pc_mux)
      PC_BOOT: boot_addr_i = cur_row.target;
      PC_JUMP: branch_target_i = cur_row.target;
      PC_EXC:  csr_mtvec_i = cur_row.target;
      PC_ERET: csr_mepc_i = cur_row.target;
      default: csr_depc_i = cur_row.target;
    endcase
    pc_mux_i     = cur_row.pc_mux;
    exc_pc_mux_i = cur_row.exc_mux;
  endtask

  // drives one clock of memory and ID side stimulus 1 ns after the edge
  task automatic drive_cycle(input logic do_set);
    logic [AddrWidth-1:0] addr;
    @(posedge clk_i);
    #1;
    instr_rsp_i.gnt    = (($random(seed) & 3) != 0);
    grant_lat          = 1 + ($unsigned($random(seed)) % 3);
    instr_rsp_i.rvalid = 1'b0;
    instr_rsp_i.rdata  = '0;
    instr_rsp_i.err    = 1'b0;
    if (pend_addr.size() > 0 && pend_due[0] <= cycle) begin
      addr = pend_addr.pop_front();
      void'(pend_due.pop_front());
      instr_rsp_i.rvalid = 1'b1;
      instr_rsp_i.rdata  = ~addr;
      instr_rsp_i.err    = in_err_window(addr);
    end
    pc_set_i = do_set;
    boot_set = do_set && (cur_row.pc_mux == PC_BOOT);
    if (do_set) begin
      load_sources();
      id_in_ready_i = 1'b0;
      row_cyc = 0;
    end else if (cur_row.ready_pat == 8'h00) begin
      if (stall_left > 0) begin
        id_in_ready_i = 1'b0;
        stall_left--;
      end else if (($random(seed) & 7) == 0) begin
        id_in_ready_i = 1'b0;
        stall_left = $unsigned($random(seed)) % 5;
      end else begin
        id_in_ready_i = 1'b1;
      end
    end else begin
      id_in_ready_i = cur_row.ready_pat[row_cyc % 8];
    end
    instr_valid_clear_i = id_in_ready_i | do_set;
    row_cyc++;
  endtask

  // the memory records each grant and answers in order after 1 to 3 cycles
  always @(negedge clk_i) begin : record_requests
    int due;
    if (rst_ni) begin
      if (bus_waiting) begin
        assert (instr_req_o.req && instr_req_o.addr == waiting_addr) else begin
          errors++;
          $display("request was dropped or moved while it waited for its grant");
        end
      end
      bus_waiting  = instr_req_o.req & ~instr_rsp_i.gnt;
      waiting_addr = instr_req_o.addr;
      if (instr_req_o.req && instr_rsp_i.gnt) begin
        due = cycle + grant_lat;
        if (due <= last_due) begin
          due = last_due + 1;
        end
        pend_addr.push_back(instr_req_o.addr);
        pend_due.push_back(due);
        last_due = due;
      end
    end
  end

  always @(negedge clk_i) begin : check_outputs
    logic exp_valid;
    if (rst_ni) begin
      check_value("pc_mismatch_alert_o", pc_mismatch_alert_o, 32'h0);
      check_value("csr_mtvec_init_o", csr_mtvec_init_o, boot_set);
      // valid rises after a pop and holds until the ID stage clears it
      exp_valid = instr_new_id_o | (valid_exp_q & ~clear_prev);
      check_value("instr_valid_id_o", instr_valid_id_o, exp_valid);
      valid_exp_q = exp_valid;
      clear_prev  = instr_valid_clear_i;
      if (!started) begin
        check_value("instr_req_o.req", instr_req_o.req, 32'h0);
      end
      if (instr_new_id_o) begin
        assert (started) else begin
          errors++;
          $display("an instruction reached ID before the first PC set");
        end
        assert (ready_prev) else begin
          errors++;
          $display("an instruction reached ID although ID was not ready before");
        end
        check_value("instr_id_o.addr", instr_id_o.addr, exp_pc);
        check_value("instr_id_o.rdata", instr_id_o.rdata, ~exp_pc);
        check_value("instr_id_o.err", instr_id_o.err, in_err_window(exp_pc));
        exp_pc = exp_pc + 32'd4;
        consumed++;
        n_instr++;
      end
      // IF shows the address of the next instruction that ID will take
      if (started && !pc_set_i) begin
        check_value("pc_if_o", pc_if_o, exp_pc);
      end
      ready_prev = id_in_ready_i;
      if (pc_set_i) begin
        exp_pc   = cur_row.first_pc;
        consumed = 0;
        started  = 1'b1;
      end
    end
  end

  always @(posedge clk_i) begin
    cycle <= cycle + 1;
    if (cycle > limit) begin
      $display("timeout, run still busy after %0d cycles with %0d errors", cycle, errors);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  initial begin
    seed = 32'hb3c63c3c;
    rows[0] = '{PC_BOOT, EXC_PC_EXC,     32'h0000_1082, 32'h0000_1080, 8'd10, 8'hff};
    rows[1] = '{PC_JUMP, EXC_PC_EXC,     32'h0000_1ff8, 32'h0000_1ff8, 8'd8,  8'hff};
    rows[2] = '{PC_EXC,  EXC_PC_EXC,     32'h0000_3001, 32'h0000_3000, 8'd5,  8'b1011_0110};
    rows[3] = '{PC_EXC,  EXC_PC_IRQ,     32'h0000_3103, 32'h0000_3100, 8'd5,  8'hff};
    rows[4] = '{PC_EXC,  EXC_PC_DBD,     32'h0000_3200, 32'h1A11_0800, 8'd4,  8'hff};
    rows[5] = '{PC_EXC,  EXC_PC_DBG_EXC, 32'h0000_3300, 32'h1A11_0808, 8'd4,  8'b0101_0101};
    rows[6] = '{PC_ERET, EXC_PC_EXC,     32'h0000_4444, 32'h0000_4444, 8'd6,  8'h00};
    rows[7] = '{PC_DRET, EXC_PC_EXC,     32'h0000_5550, 32'h0000_5550, 8'd6,  8'hff};
    rows[8] = '{PC_JUMP, EXC_PC_EXC,     32'h0000_2006, 32'h0000_2004, 8'd12, 8'h00};
    rows[9] = '{PC_BOOT, EXC_PC_EXC,     32'h0000_0100, 32'h0000_0100, 8'd16, 8'h00};
    limit = 200;
    for (int i = 0; i < NumRows; i++) begin
      limit += rows[i].count * 10;
    end
    cur_row             = rows[0];
    rst_ni              = 1'b0;
    req_i               = 1'b0;
    pc_set_i            = 1'b0;
    pc_mux_i            = PC_BOOT;
    exc_pc_mux_i        = EXC_PC_EXC;
    boot_addr_i         = '0;
    branch_target_i     = '0;
    csr_mepc_i          = '0;
    csr_depc_i          = '0;
    csr_mtvec_i         = '0;
    id_in_ready_i       = 1'b0;
    instr_valid_clear_i = 1'b0;
    instr_rsp_i         = '0;
    repeat (3) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    // nothing may be fetched in these idle cycles before the first set
    req_i = 1'b1;
    repeat (4) drive_cycle(1'b0);
    for (int i = 0; i < NumRows; i++) begin
      cur_row = rows[i];
      drive_cycle(1'b1);
      do begin
        drive_cycle(1'b0);
      end while (consumed < cur_row.count);
    end
    repeat (6) drive_cycle(1'b0);
    $display("%0d instructions checked, %0d errors", n_instr, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// ==== all.f ====
logic/ifu_ctrl_pkg.sv
logic/ifu_bus_pkg.sv
logic/ifu_pc_select.sv
logic/ifu_prefetch_buffer.sv
logic/ifu_id_reg.sv
logic/ifu_pc_check.sv
logic/ifu_top.sv
dv/ifu_tb.sv

// ==== Bender.yml ====
package:
  name: ifu

sources:
  - logic/ifu_ctrl_pkg.sv
  - logic/ifu_bus_pkg.sv
  - logic/ifu_pc_select.sv
  - logic/ifu_prefetch_buffer.sv
  - logic/ifu_id_reg.sv
  - logic/ifu_pc_check.sv
  - logic/ifu_top.sv
  - target: test
    files:
      - dv/ifu_tb.sv
